/* hw/ladder_pkg.sv */
/*
 * Ladder layer definitions. VGA stream struct, map region table,
 * sprite rule and colour constants.
 */
package ladder_pkg;

    typedef struct packed {
        logic [10:0] hcount;
        logic        hsync;
        logic        hblnk;
        logic [10:0] vcount;
        logic        vsync;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_sig_t;

    // Row bounds inclusive, column stop exclusive.
    typedef struct packed {
        logic [10:0] vstart;
        logic [10:0] vstop;
        logic [10:0] hstart;
        logic [10:0] hstop;
        logic        use_offset;
    } region_t;

    // ==================================================
    // Map regions, highest priority first.
    // ==================================================
    localparam int NUM_REGIONS = 8;

    localparam region_t REGION_TABLE [NUM_REGIONS] = '{
        '{11'd641, 11'd736, 11'd800, 11'd832, 1'b1},  // Ladder 1.
        '{11'd588, 11'd640, 11'd320, 11'd352, 1'b0},  // Decoration A, upper.
        '{11'd704, 11'd736, 11'd320, 11'd352, 1'b0},  // Decoration A, lower.
        '{11'd500, 11'd587, 11'd160, 11'd192, 1'b1},  // Ladder 2.
        '{11'd387, 11'd499, 11'd704, 11'd736, 1'b1},  // Ladder 3.
        '{11'd271, 11'd386, 11'd256, 11'd288, 1'b1},  // Ladder 4.
        '{11'd271, 11'd302, 11'd576, 11'd608, 1'b0},  // Decoration B, upper.
        '{11'd354, 11'd386, 11'd576, 11'd608, 1'b0}   // Decoration B, lower.
    };

    localparam int RAMP_OFFSET = 16;
    localparam int SPRITE_AW   = 10;
    localparam int PIPE_DEPTH  = 3;

    // ==================================================
    // Sprite rule and colours
    // ==================================================
    localparam logic [11:0] LADDER_RGB = 12'hA62;
    localparam logic [11:0] SHADE_RGB  = 12'h311;
    localparam logic [11:0] BLANK_RGB  = 12'h888;

    localparam int RAIL_L_LO   = 2;
    localparam int RAIL_L_HI   = 4;
    localparam int RAIL_R_LO   = 27;
    localparam int RAIL_R_HI   = 29;
    localparam int RUNG_PERIOD = 8;

    // Rails on both sides, a rung every eighth row.
    function automatic logic [11:0] sprite_texel(input int unsigned row,
                                                 input int unsigned col);
        logic rail;
        logic rung;
        rail = ((col >= RAIL_L_LO) && (col <= RAIL_L_HI)) ||
               ((col >= RAIL_R_LO) && (col <= RAIL_R_HI));
        rung = (row % RUNG_PERIOD) == 0;
        return (rail || rung) ? LADDER_RGB : SHADE_RGB;
    endfunction

endpackage

/* hw/vga_delay.sv */
/*
 * VGA stream delay line. Carries timing and background colour
 * through DEPTH register stages.
 */
`timescale 1ns/1ps

module vga_delay #(
    parameter int DEPTH = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  ladder_pkg::vga_sig_t din,
    output ladder_pkg::vga_sig_t dout
);

    ladder_pkg::vga_sig_t stage [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];  // Oldest pixel.

endmodule

/* hw/ladder_region_decode.sv */
/*
 * Ladder region decoder. Finds the first map region holding the
 * pixel and forms the sprite address for it.
 */
`timescale 1ns/1ps

module ladder_region_decode (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start_game,
    input  logic                             animation,
    input  ladder_pkg::vga_sig_t             pix,
    output logic                             hit,
    output logic [ladder_pkg::SPRITE_AW-1:0] sprite_addr
);

    import ladder_pkg::*;

    logic                 match;
    logic                 use_offset;
    logic                 active;
    logic [10:0]          hcount_off;
    logic [4:0]           col;
    logic                 hit_nxt;
    logic [SPRITE_AW-1:0] sprite_addr_nxt;

    // ==================================================
    // Region scan
    // ==================================================
    always_comb begin
        match      = 1'b0;
        use_offset = 1'b0;
        for (int i = 0; i < NUM_REGIONS; i++) begin
            if (!match &&
                (pix.vcount >= REGION_TABLE[i].vstart) &&
                (pix.vcount <= REGION_TABLE[i].vstop) &&
                (pix.hcount >= REGION_TABLE[i].hstart) &&
                (pix.hcount <  REGION_TABLE[i].hstop)) begin
                match      = 1'b1;
                use_offset = REGION_TABLE[i].use_offset;
            end
        end
    end

    // Ramps shift the sprite sideways.
    assign hcount_off = pix.hcount + 11'(RAMP_OFFSET);
    assign col        = use_offset ? hcount_off[4:0] : pix.hcount[4:0];

    assign active = !pix.hblnk && !pix.vblnk && start_game && !animation;

    always_comb begin
        hit_nxt         = active && match;
        sprite_addr_nxt = sprite_addr;  // Hold on miss.
        if (hit_nxt) begin
            sprite_addr_nxt = {pix.vcount[4:0], col};
        end
    end

    // ==================================================
    // Stage register
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            hit         <= 1'b0;
            sprite_addr <= '0;
        end else begin
            hit         <= hit_nxt;
            sprite_addr <= sprite_addr_nxt;
        end
    end

endmodule

/* hw/ladder_sprite_rom.sv */
/*
 * Ladder sprite ROM with registered read. The hit flag travels
 * beside the texel.
 */
`timescale 1ns/1ps

module ladder_sprite_rom #(
    parameter int SPRITE_AW = ladder_pkg::SPRITE_AW
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 hit,
    input  logic [SPRITE_AW-1:0] addr,
    output logic                 hit_q,
    output logic [11:0]          texel
);

    import ladder_pkg::*;

    localparam int WORDS  = 2 ** SPRITE_AW;
    localparam int SIDE_W = SPRITE_AW / 2;

    logic [11:0] mem [WORDS];

    // Row in the upper half of the address, column in the lower.
    initial begin
        for (int a = 0; a < WORDS; a++) begin
            mem[a] = sprite_texel(a >> SIDE_W, a % (2 ** SIDE_W));
        end
    end

    always_ff @(posedge clk) begin
        texel <= mem[addr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= hit;
        end
    end

endmodule

/* hw/ladder_pixel_merge.sv */
/*
 * Ladder pixel merge. Picks blank grey, sprite texel or background
 * and registers the output stream.
 */
`timescale 1ns/1ps

module ladder_pixel_merge (
    input  logic                 clk,
    input  logic                 rst,
    input  ladder_pkg::vga_sig_t pix_d,
    input  logic                 hit_q,
    input  logic [11:0]          texel,
    output ladder_pkg::vga_sig_t out
);

    import ladder_pkg::*;

    vga_sig_t out_nxt;

    always_comb begin
        out_nxt = pix_d;
        if (pix_d.hblnk || pix_d.vblnk) begin
            out_nxt.rgb = BLANK_RGB;
        end else if (hit_q) begin
            out_nxt.rgb = texel;
        end
        // Otherwise background passes through.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '0;
        end else begin
            out <= out_nxt;
        end
    end

endmodule

/* hw/ladder_draw_top.sv */
/*
 * Ladder layer top. Decode, sprite fetch and merge stages with the
 * VGA delay line, three cycles from input to output.
 */
`timescale 1ns/1ps

module ladder_draw_top #(
    parameter int SPRITE_AW = ladder_pkg::SPRITE_AW
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start_game,
    input  logic                 animation,
    input  ladder_pkg::vga_sig_t in,
    output ladder_pkg::vga_sig_t out
);

    import ladder_pkg::*;

    logic                 hit;
    logic [SPRITE_AW-1:0] sprite_addr;
    logic                 hit_q;
    logic [11:0]          texel;
    vga_sig_t             pix_d;

    ladder_region_decode u_decode (
        .clk,
        .rst,
        .start_game,
        .animation,
        .pix         (in),
        .hit,
        .sprite_addr
    );

    ladder_sprite_rom #(
        .SPRITE_AW (SPRITE_AW)
    ) u_rom (
        .clk,
        .rst,
        .hit,
        .addr  (sprite_addr),
        .hit_q,
        .texel
    );

    // Merge adds the last cycle.
    vga_delay #(
        .DEPTH (PIPE_DEPTH - 1)
    ) u_delay (
        .clk,
        .rst,
        .din  (in),
        .dout (pix_d)
    );

    ladder_pixel_merge u_merge (
        .clk,
        .rst,
        .pix_d,
        .hit_q,
        .texel,
        .out
    );

endmodule

/* verification/ladder_draw_tb.sv */
/*
 * Ladder layer testbench. Random pixels from a fixed seed are checked
 * against a reference model of the region map, sprite and colour rules.
 */
`timescale 1ns/1ps

module ladder_draw_tb;

    import ladder_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int N_PASS = 2000;
    localparam int N_BLANK = 200;
    localparam int N_GATE = 200;
    localparam int N_SPRITE = 100;
    localparam int N_BACK = 1000;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 2 + N_PASS + N_BLANK + 2 * N_GATE +
                                  8 * N_SPRITE + N_BACK + 8 * 8 + 6 * 3;
    localparam int WATCHDOG_NS = (TOTAL_CYCLES + 200) * CLK_PERIOD;

    // ==================================================
    // Reference map, highest priority first.
    // ==================================================
    localparam int MAP_VSTART [8] = '{641, 588, 704, 500, 387, 271, 271, 354};
    localparam int MAP_VSTOP  [8] = '{736, 640, 736, 587, 499, 386, 302, 386};
    localparam int MAP_HSTART [8] = '{800, 320, 320, 160, 704, 256, 576, 576};
    localparam int MAP_HSTOP  [8] = '{832, 352, 352, 192, 736, 288, 608, 608};
    localparam bit MAP_OFFSET [8] = '{1, 0, 0, 1, 1, 1, 0, 0};

    localparam int          OFFSET_COLS = 16;
    localparam logic [11:0] RAIL_COLOUR = 12'hA62;
    localparam logic [11:0] FILL_COLOUR = 12'h311;
    localparam logic [11:0] GREY        = 12'h888;

    logic     clk;
    logic     rst;
    logic     start_game;
    logic     animation;
    vga_sig_t dut_in;
    vga_sig_t dut_out;

    int          seed = 95662;
    int unsigned rnd;
    int          checks = 0;
    int          errors = 0;
    int          test_checks0;
    int          test_errors0;

    vga_sig_t pix_q [$];  // Pixels in flight.
    logic     run_q [$];

    ladder_draw_top #(
        .SPRITE_AW (SPRITE_AW)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .start_game (start_game),
        .animation  (animation),
        .in         (dut_in),
        .out        (dut_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the tests did not finish in the expected time.");
        $display("TESTS FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %0h expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [11:0] ladder_texel(input logic [4:0] row, input logic [4:0] col);
        if ((col >= 2 && col <= 4) || (col >= 27 && col <= 29) || row[2:0] == 3'd0) begin
            return RAIL_COLOUR;
        end
        return FILL_COLOUR;
    endfunction

    function automatic logic [11:0] expected_rgb(input vga_sig_t p, input logic running);
        logic        found;
        logic        off;
        logic [10:0] hc;
        int          hpos;
        int          vpos;
        found = 1'b0;
        off   = 1'b0;
        hpos  = int'(p.hcount);
        vpos  = int'(p.vcount);
        if (p.hblnk || p.vblnk) begin
            return GREY;
        end
        for (int r = 0; r < 8; r++) begin
            if (!found && vpos >= MAP_VSTART[r] && vpos <= MAP_VSTOP[r] &&
                hpos >= MAP_HSTART[r] && hpos < MAP_HSTOP[r]) begin
                found = 1'b1;
                off   = MAP_OFFSET[r];
            end
        end
        if (!running || !found) begin
            return p.rgb;
        end
        hc = off ? p.hcount + 11'(OFFSET_COLS) : p.hcount;
        return ladder_texel(p.vcount[4:0], hc[4:0]);
    endfunction

    // Check the pixel leaving the pipeline, then drive the next one.
    task automatic step(input vga_sig_t pix, input logic start, input logic anim);
        vga_sig_t exp_pix;
        logic     exp_run;
        @(negedge clk);
        if (pix_q.size() == 3) begin
            exp_pix = pix_q.pop_front();
            exp_run = run_q.pop_front();
            check_value("out.timing", 64'(dut_out[37:12]), 64'(exp_pix[37:12]));
            check_value("out.rgb", 64'(dut_out.rgb), 64'(expected_rgb(exp_pix, exp_run)));
        end
        dut_in     = pix;
        start_game = start;
        animation  = anim;
        pix_q.push_back(pix);
        run_q.push_back(start && !anim);
    endtask

    task automatic make_pixel(input int h, input int v, input logic hb, input logic vb,
                              output vga_sig_t p);
        rnd = $random(seed);
        p.hcount = 11'(h);
        p.vcount = 11'(v);
        p.hsync  = rnd[12];
        p.vsync  = rnd[13];
        p.hblnk  = hb;
        p.vblnk  = vb;
        p.rgb    = rnd[11:0];
    endtask

    task automatic pick_frame(output int h, output int v);
        rnd = $random(seed);
        h   = int'(rnd % 1344);
        rnd = $random(seed);
        v   = int'(rnd % 806);
    endtask

    task automatic pick_region(input int r, output int h, output int v);
        rnd = $random(seed);
        v   = MAP_VSTART[r] + int'(rnd % (MAP_VSTOP[r] - MAP_VSTART[r] + 1));
        rnd = $random(seed);
        h   = MAP_HSTART[r] + int'(rnd % (MAP_HSTOP[r] - MAP_HSTART[r]));
    endtask

    task automatic drain();
        vga_sig_t p;
        for (int i = 0; i < 3; i++) begin
            make_pixel(0, 0, 1'b1, 1'b1, p);
            step(p, 1'b0, 1'b0);
        end
    endtask

    task automatic begin_test();
        test_checks0 = checks;
        test_errors0 = errors;
    endtask

    task automatic end_test(input string name);
        drain();
        $display("%-18s checks %0d errors %0d", name, checks - test_checks0,
                 errors - test_errors0);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        vga_sig_t p;
        int       h;
        int       v;
        rst        = 1'b1;
        start_game = 1'b0;
        animation  = 1'b0;
        dut_in     = '0;

        begin_test();
        // Live pixels keep arriving while reset holds the pipeline clear.
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_value("out", 64'(dut_out), 64'd0);
            pick_frame(h, v);
            make_pixel(h, v, 1'b0, 1'b0, p);
            dut_in     = p;
            start_game = 1'b1;
            animation  = 1'b0;
        end
        rst = 1'b0;
        pix_q.push_back(dut_in);  // Last pixel sampled on the release edge.
        run_q.push_back(start_game && !animation);
        @(negedge clk);
        check_value("out", 64'(dut_out), 64'd0);  // First cycle after reset.
        pix_q.push_back(dut_in);
        run_q.push_back(start_game && !animation);
        end_test("reset");

        begin_test();
        for (int i = 0; i < N_PASS; i++) begin
            pick_frame(h, v);
            rnd = $random(seed);
            make_pixel(h, v, rnd[2:0] == 3'd0, rnd[5:3] == 3'd0, p);
            step(p, rnd[8], rnd[10:9] == 2'd0);
        end
        end_test("pass_through");

        begin_test();
        for (int i = 0; i < N_BLANK; i++) begin
            rnd = $random(seed);
            if (rnd[0]) begin
                pick_region(int'(rnd[6:4]), h, v);
            end else begin
                pick_frame(h, v);
            end
            rnd = $random(seed);
            make_pixel(h, v, rnd[0] || !rnd[1], rnd[1], p);
            step(p, rnd[2], rnd[3]);
        end
        end_test("blanking");

        begin_test();
        for (int i = 0; i < 2 * N_GATE; i++) begin
            rnd = $random(seed);
            pick_region(int'(rnd[2:0]), h, v);
            make_pixel(h, v, 1'b0, 1'b0, p);
            // Game stopped first, then running with an animation.
            step(p, i >= N_GATE, i >= N_GATE ? 1'b1 : rnd[4]);
        end
        end_test("game_gating");

        begin_test();
        for (int r = 0; r < 8; r++) begin
            for (int i = 0; i < N_SPRITE; i++) begin
                pick_region(r, h, v);
                make_pixel(h, v, 1'b0, 1'b0, p);
                step(p, 1'b1, 1'b0);
            end
        end
        end_test("sprite_draw");

        begin_test();
        for (int i = 0; i < N_BACK; i++) begin
            rnd = $random(seed);
            h   = int'(rnd % 1024);
            rnd = $random(seed);
            v   = int'(rnd % 768);
            make_pixel(h, v, 1'b0, 1'b0, p);
            step(p, 1'b1, 1'b0);
        end
        for (int r = 0; r < 8; r++) begin
            for (int k = 0; k < 8; k++) begin
                pick_region(r, h, v);
                case (k)
                    0: v = MAP_VSTART[r];
                    1: v = MAP_VSTOP[r];
                    2: v = MAP_VSTART[r] - 1;
                    3: v = MAP_VSTOP[r] + 1;
                    4: h = MAP_HSTART[r];
                    5: h = MAP_HSTOP[r] - 1;
                    6: h = MAP_HSTOP[r];
                    default: h = MAP_HSTART[r] - 1;
                endcase
                make_pixel(h, v, 1'b0, 1'b0, p);
                step(p, 1'b1, 1'b0);
            end
        end
        end_test("background_edges");

        $display("Total checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* ladder_draw.f */
hw/ladder_pkg.sv
hw/vga_delay.sv
hw/ladder_region_decode.sv
hw/ladder_sprite_rom.sv
hw/ladder_pixel_merge.sv
hw/ladder_draw_top.sv
verification/ladder_draw_tb.sv

/* Makefile */
# Verilator simulation of the ladder layer.

VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = ladder_draw_tb
FILELIST  = ladder_draw.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@result="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$result"; \
	echo "$$result" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
